//--- all.f
hdl/pspin_cfg_pkg.sv
hdl/pspin_descr_pkg.sv
hdl/her_fifo.sv
hdl/mpq_engine.sv
hdl/task_scheduler.sv
hdl/pspin_top.sv
bench/tb_pspin.sv

//--- bench/tb_pspin.sv
// Testbench for the packet handling top level with random HERs and cluster and NIC responders
`timescale 1ns/10ps

module tb_pspin;

  localparam int NC = pspin_cfg_pkg::NUM_CLUSTERS;
  localparam int NUM_RANDOM_HERS = 200;
  localparam int NUM_FULL_HERS = 20;
  localparam int FULL_LIMIT = pspin_cfg_pkg::MPQ_DEPTH + 1 + NC;
  localparam int TIMEOUT_CYCLES = (NUM_RANDOM_HERS + NUM_FULL_HERS) * 200;

  logic                                      clk_i;
  logic                                      rst_ni;
  logic                                      her_valid_i;
  logic                                      her_ready_o;
  pspin_descr_pkg::her_descr_t               her_i;
  logic [pspin_cfg_pkg::NUM_MPQ-1:0]         mpq_full_o;
  logic                                      nic_feedback_valid_o;
  logic                                      nic_feedback_ready_i;
  pspin_descr_pkg::feedback_descr_t          nic_feedback_o;
  logic [NC-1:0]                             cluster_task_valid_o;
  logic [NC-1:0]                             cluster_task_ready_i;
  pspin_descr_pkg::handler_task_t [NC-1:0]   cluster_task_o;
  logic [NC-1:0]                             cluster_fb_valid_i;
  logic [NC-1:0]                             cluster_fb_ready_o;
  pspin_descr_pkg::feedback_descr_t [NC-1:0] cluster_fb_i;

  // Reference model state
  pspin_descr_pkg::her_descr_t      exp_q [pspin_cfg_pkg::NUM_MPQ][$];
  pspin_descr_pkg::handler_task_t   cl_q [NC][$];
  pspin_descr_pkg::handler_task_t   slot_task [NC];
  bit slot_busy [NC];
  pspin_descr_pkg::feedback_descr_t nic_exp [$];
  int outstanding [NC];
  int fb_delay [NC];
  logic [31:0] gen_state;
  logic [31:0] resp_state;
  bit hold_clusters;
  int errors;
  int checks;
  int hers_accepted;
  int tasks_seen;
  int fb_seen;
  int nic_seen;

  pspin_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {state[15:0], state[31:16]};
  endfunction

  // Negative mpq picks a random queue
  function automatic pspin_descr_pkg::her_descr_t make_her(input int mpq);
    pspin_descr_pkg::her_descr_t her;
    logic [31:0] r;
    r = lcg_next(gen_state);
    her.mpq_id = (mpq < 0) ? r[pspin_cfg_pkg::MPQ_ID_W-1:0] : mpq[pspin_cfg_pkg::MPQ_ID_W-1:0];
    her.msg_id = r[23:16];
    her.pkt_size = r[31:16];
    her.handler_addr = lcg_next(gen_state);
    her.pkt_addr = lcg_next(gen_state);
    return her;
  endfunction

  function automatic pspin_descr_pkg::handler_task_t task_of(
    input pspin_descr_pkg::her_descr_t her);
    pspin_descr_pkg::handler_task_t t;
    t.mpq_id = her.mpq_id;
    t.msg_id = her.msg_id;
    t.handler_addr = her.handler_addr;
    t.pkt_addr = her.pkt_addr;
    t.pkt_size = her.pkt_size;
    return t;
  endfunction

  function automatic bit model_idle();
    bit idle;
    idle = (nic_exp.size() == 0);
    for (int q = 0; q < pspin_cfg_pkg::NUM_MPQ; q++) begin
      if (exp_q[q].size() != 0) idle = 1'b0;
    end
    for (int c = 0; c < NC; c++) begin
      if (cl_q[c].size() != 0 || slot_busy[c]) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: actual 0x%0h expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    $display("[%0d] %s: %0d errors", num, name, errors - err_start);
  endtask

  // Caller is aligned to a rising edge
  task automatic send_her(input pspin_descr_pkg::her_descr_t her);
    her_valid_i <= 1'b1;
    her_i <= her;
    do @(posedge clk_i); while (!her_ready_o);
    her_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    do @(posedge clk_i); while (!model_idle());
  endtask

  // Cluster and NIC responders with the scoreboard
  always @(posedge clk_i) begin
    pspin_descr_pkg::handler_task_t t;
    pspin_descr_pkg::feedback_descr_t f;
    logic [31:0] r;
    if (!rst_ni) begin
      cluster_task_ready_i <= '0;
      cluster_fb_valid_i <= '0;
      nic_feedback_ready_i <= 1'b0;
    end else begin
      if (her_valid_i && her_ready_o) begin
        exp_q[her_i.mpq_id].push_back(her_i);
        hers_accepted++;
      end
      for (int c = 0; c < NC; c++) begin
        // Slots fill in issue order, so per-MPQ order is checked on arrival
        if (cluster_task_valid_o[c] && !slot_busy[c]) begin
          t = cluster_task_o[c];
          if (exp_q[t.mpq_id].size() == 0) begin
            errors++;
            $display("ERROR: cluster %0d got a task for MPQ %0d with no HER pending", c,
                     t.mpq_id);
          end else begin
            check_value("cluster_task_o", t, task_of(exp_q[t.mpq_id].pop_front()));
          end
          slot_task[c] = t;
          slot_busy[c] = 1'b1;
          tasks_seen++;
        end
        if (cluster_task_valid_o[c] && cluster_task_ready_i[c]) begin
          check_value("cluster_task_o", cluster_task_o[c], slot_task[c]);
          slot_busy[c] = 1'b0;
          outstanding[c]++;
          if (outstanding[c] > pspin_cfg_pkg::NUM_HERS_PER_CLUSTER) begin
            errors++;
            $display("ERROR: cluster %0d holds %0d tasks without feedback", c, outstanding[c]);
          end
          cl_q[c].push_back(slot_task[c]);
        end
        if (cluster_fb_valid_i[c] && cluster_fb_ready_o[c]) begin
          t = cl_q[c].pop_front();
          outstanding[c]--;
          f.mpq_id = t.mpq_id;
          f.msg_id = t.msg_id;
          f.pkt_addr = t.pkt_addr;
          f.cluster_id = c[pspin_cfg_pkg::CLUSTER_ID_W-1:0];
          nic_exp.push_back(f);
          fb_seen++;
          cluster_fb_valid_i[c] <= 1'b0;
          fb_delay[c] = lcg_next(resp_state) % 8;
        end else if (!cluster_fb_valid_i[c] && cl_q[c].size() != 0) begin
          if (fb_delay[c] == 0) begin
            r = lcg_next(resp_state);
            f.mpq_id = cl_q[c][0].mpq_id;
            f.msg_id = cl_q[c][0].msg_id;
            f.pkt_addr = cl_q[c][0].pkt_addr;
            // Junk index that the scheduler must replace
            f.cluster_id = r[pspin_cfg_pkg::CLUSTER_ID_W-1:0];
            cluster_fb_i[c] <= f;
            cluster_fb_valid_i[c] <= 1'b1;
          end else begin
            fb_delay[c]--;
          end
        end
        cluster_task_ready_i[c] <= !hold_clusters && (lcg_next(resp_state) % 4 != 0);
      end
      if (nic_feedback_valid_o && nic_feedback_ready_i) begin
        if (nic_exp.size() == 0) begin
          errors++;
          $display("ERROR: NIC feedback appeared with none expected");
        end else begin
          check_value("nic_feedback_o", nic_feedback_o, nic_exp.pop_front());
        end
        nic_seen++;
      end
      nic_feedback_ready_i <= (lcg_next(resp_state) % 3 != 0);
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles with traffic still pending",
             TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    int err_start;
    int accepted;
    bit saw_full;
    logic [pspin_cfg_pkg::NUM_MPQ-1:0] full_exp;
    rst_ni = 1'b0;
    her_valid_i = 1'b0;
    her_i = '0;
    cluster_task_ready_i = '0;
    cluster_fb_valid_i = '0;
    cluster_fb_i = '0;
    nic_feedback_ready_i = 1'b0;
    hold_clusters = 1'b0;
    gen_state = 32'h6fcb;
    resp_state = lcg_next(gen_state);
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(posedge clk_i);
    err_start = errors;
    check_value("her_ready_o", her_ready_o, 1'b1);
    check_value("cluster_task_valid_o", cluster_task_valid_o, '0);
    check_value("nic_feedback_valid_o", nic_feedback_valid_o, 1'b0);
    report_test(1, "reset values", err_start);

    err_start = errors;
    for (int i = 0; i < NUM_RANDOM_HERS; i++) begin
      send_her(make_her(-1));
      repeat (lcg_next(gen_state) % 3) @(posedge clk_i);
    end
    wait_idle();
    check_value("task_count", tasks_seen, hers_accepted);
    check_value("nic_feedback_count", nic_seen, fb_seen);
    report_test(2, "random traffic", err_start);

    // Stall every cluster and fill MPQ 2
    err_start = errors;
    hold_clusters = 1'b1;
    repeat (2) @(posedge clk_i);
    accepted = 0;
    saw_full = 1'b0;
    her_valid_i <= 1'b1;
    her_i <= make_her(2);
    for (int i = 0; i < NUM_FULL_HERS && !saw_full; i++) begin
      @(posedge clk_i);
      if (her_ready_o) begin
        accepted++;
        her_i <= make_her(2);
      end else begin
        saw_full = 1'b1;
      end
    end
    if (saw_full) begin
      full_exp = '0;
      full_exp[2] = 1'b1;
      check_value("mpq_full_o", mpq_full_o, full_exp);
      if (accepted > FULL_LIMIT) begin
        errors++;
        $display("ERROR: %0d HERs accepted before her_ready_o fell, limit %0d", accepted, FULL_LIMIT);
      end
    end else begin
      errors++;
      $display("ERROR: her_ready_o never fell with all clusters stalled");
    end
    hold_clusters = 1'b0;
    do @(posedge clk_i); while (!her_ready_o);
    her_valid_i <= 1'b0;
    wait_idle();
    check_value("task_count", tasks_seen, hers_accepted);
    check_value("nic_feedback_count", nic_seen, fb_seen);
    report_test(3, "full MPQ and drain", err_start);

    $display("%0d checks, %0d errors, %0d HERs, %0d feedbacks", checks, errors, hers_accepted,
             nic_seen);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- hdl/her_fifo.sv
// Single MPQ queue holding HER descriptors in a circular buffer
`timescale 1ns/10ps

module her_fifo (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  pspin_descr_pkg::her_descr_t her_i,
  input  logic                        pop_i,
  output pspin_descr_pkg::her_descr_t her_o,
  output logic                        empty_o,
  output logic                        full_o
);

  typedef logic [pspin_cfg_pkg::MPQ_PTR_W-1:0] ptr_t;
  typedef logic [pspin_cfg_pkg::MPQ_CNT_W-1:0] cnt_t;

  pspin_descr_pkg::her_descr_t mem_q [pspin_cfg_pkg::MPQ_DEPTH];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;

  // Wraps at MPQ_DEPTH, which need not be a power of two
  function automatic ptr_t ptr_next(input ptr_t ptr);
    if (ptr == ptr_t'(pspin_cfg_pkg::MPQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= her_i;
    end
  end

  assign her_o   = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(pspin_cfg_pkg::MPQ_DEPTH));

  // Steering logic upstream must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("HER pushed into a full MPQ queue");

  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("HER popped from an empty MPQ queue");

endmodule

//--- hdl/mpq_engine.sv
// MPQ engine with per-MPQ HER queues, round-robin task issue and feedback return to the NIC
`timescale 1ns/10ps

module mpq_engine (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic                                   her_valid_i,
  output logic                                   her_ready_o,
  input  pspin_descr_pkg::her_descr_t            her_i,

  output logic [pspin_cfg_pkg::NUM_MPQ-1:0]      mpq_full_o,

  output logic                                   task_valid_o,
  input  logic                                   task_ready_i,
  output pspin_descr_pkg::handler_task_t         task_o,

  input  logic                                   fb_valid_i,
  output logic                                   fb_ready_o,
  input  pspin_descr_pkg::feedback_descr_t       fb_i,

  output logic                                   nic_feedback_valid_o,
  input  logic                                   nic_feedback_ready_i,
  output pspin_descr_pkg::feedback_descr_t       nic_feedback_o
);

  typedef logic [pspin_cfg_pkg::MPQ_ID_W-1:0] mpq_idx_t;

  logic [pspin_cfg_pkg::NUM_MPQ-1:0] push;
  logic [pspin_cfg_pkg::NUM_MPQ-1:0] pop;
  logic [pspin_cfg_pkg::NUM_MPQ-1:0] empty;
  logic [pspin_cfg_pkg::NUM_MPQ-1:0] full;
  pspin_descr_pkg::her_descr_t [pspin_cfg_pkg::NUM_MPQ-1:0] head;

  logic                             her_fire;
  mpq_idx_t                         rr_q;
  mpq_idx_t                         sel;
  logic                             sel_valid;
  logic                             task_load;
  logic                             task_valid_q;
  pspin_descr_pkg::handler_task_t   task_q;
  logic                             fb_fire;
  logic                             nic_valid_q;
  pspin_descr_pkg::feedback_descr_t nic_fb_q;

  // Stall the generator as soon as any queue fills up
  assign her_ready_o = ~|full;
  assign her_fire    = her_valid_i && her_ready_o;
  assign mpq_full_o  = full;

  for (genvar q = 0; q < pspin_cfg_pkg::NUM_MPQ; q++) begin : gen_mpq
    assign push[q] = her_fire && (her_i.mpq_id == mpq_idx_t'(q));
    assign pop[q]  = task_load && (sel == mpq_idx_t'(q));

    her_fifo i_her_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (push[q]),
      .her_i   (her_i),
      .pop_i   (pop[q]),
      .her_o   (head[q]),
      .empty_o (empty[q]),
      .full_o  (full[q])
    );
  end

  // First non-empty queue at or after the round-robin pointer
  always_comb begin
    int idx;
    sel       = rr_q;
    sel_valid = 1'b0;
    for (int k = 0; k < pspin_cfg_pkg::NUM_MPQ; k++) begin
      idx = (int'(rr_q) + k) % pspin_cfg_pkg::NUM_MPQ;
      if (!sel_valid && !empty[idx]) begin
        sel       = mpq_idx_t'(idx);
        sel_valid = 1'b1;
      end
    end
  end

  assign task_load = sel_valid && (!task_valid_q || task_ready_i);
  assign fb_ready_o = !nic_valid_q || nic_feedback_ready_i;
  assign fb_fire    = fb_valid_i && fb_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q         <= '0;
      task_valid_q <= 1'b0;
      nic_valid_q  <= 1'b0;
    end else begin
      if (task_load) begin
        task_valid_q <= 1'b1;
        rr_q         <= mpq_idx_t'((int'(sel) + 1) % pspin_cfg_pkg::NUM_MPQ);
      end else if (task_ready_i) begin
        task_valid_q <= 1'b0;
      end
      if (fb_fire) begin
        nic_valid_q <= 1'b1;
      end else if (nic_feedback_ready_i) begin
        nic_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (task_load) begin
      task_q.mpq_id       <= head[sel].mpq_id;
      task_q.msg_id       <= head[sel].msg_id;
      task_q.handler_addr <= head[sel].handler_addr;
      task_q.pkt_addr     <= head[sel].pkt_addr;
      task_q.pkt_size     <= head[sel].pkt_size;
    end
    if (fb_fire) begin
      nic_fb_q <= fb_i;
    end
  end

  assign task_valid_o         = task_valid_q;
  assign task_o               = task_q;
  assign nic_feedback_valid_o = nic_valid_q;
  assign nic_feedback_o       = nic_fb_q;

  // The scheduler holds its feedback until it is taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fb_valid_i && !fb_ready_o |=> fb_valid_i && $stable(fb_i))
    else $error("Feedback input changed while stalled");

endmodule

//--- hdl/pspin_cfg_pkg.sv
// Task path configuration: queue sizes, cluster counts and descriptor field widths
package pspin_cfg_pkg;

  // Clusters and message processing queues
  localparam int unsigned NUM_CLUSTERS = 4;
  localparam int unsigned NUM_MPQ = 4;
  localparam int unsigned MPQ_DEPTH = 4;
  localparam int unsigned NUM_HERS_PER_CLUSTER = 2;

  // Descriptor fields
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned MSG_ID_W = 8;
  localparam int unsigned SIZE_W = 16;

  localparam int unsigned MPQ_ID_W = (NUM_MPQ > 1) ? $clog2(NUM_MPQ) : 1;
  localparam int unsigned CLUSTER_ID_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;

  // Queue pointers, queue fill level and per-cluster credits
  localparam int unsigned MPQ_PTR_W = (MPQ_DEPTH > 1) ? $clog2(MPQ_DEPTH) : 1;
  localparam int unsigned MPQ_CNT_W = $clog2(MPQ_DEPTH + 1);
  localparam int unsigned CREDIT_W = $clog2(NUM_HERS_PER_CLUSTER + 1);

endpackage

//--- hdl/pspin_descr_pkg.sv
// Descriptor types for handler execution requests, handler tasks and completion feedback
package pspin_descr_pkg;

  // Request from the packet generator
  typedef struct packed {
    logic [pspin_cfg_pkg::MPQ_ID_W-1:0] mpq_id;
    logic [pspin_cfg_pkg::MSG_ID_W-1:0] msg_id;
    logic [pspin_cfg_pkg::ADDR_W-1:0]   handler_addr;
    logic [pspin_cfg_pkg::ADDR_W-1:0]   pkt_addr;
    logic [pspin_cfg_pkg::SIZE_W-1:0]   pkt_size;
  } her_descr_t;

  // Work item handed to a cluster
  typedef struct packed {
    logic [pspin_cfg_pkg::MPQ_ID_W-1:0] mpq_id;
    logic [pspin_cfg_pkg::MSG_ID_W-1:0] msg_id;
    logic [pspin_cfg_pkg::ADDR_W-1:0]   handler_addr;
    logic [pspin_cfg_pkg::ADDR_W-1:0]   pkt_addr;
    logic [pspin_cfg_pkg::SIZE_W-1:0]   pkt_size;
  } handler_task_t;

  // Completion report naming the cluster that ran the task
  typedef struct packed {
    logic [pspin_cfg_pkg::MPQ_ID_W-1:0]     mpq_id;
    logic [pspin_cfg_pkg::MSG_ID_W-1:0]     msg_id;
    logic [pspin_cfg_pkg::ADDR_W-1:0]       pkt_addr;
    logic [pspin_cfg_pkg::CLUSTER_ID_W-1:0] cluster_id;
  } feedback_descr_t;

endpackage

//--- hdl/pspin_top.sv
// Packet handling top level: MPQ engine feeding the cluster task scheduler
`timescale 1ns/10ps

module pspin_top (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,

  // From the packet generator
  input  logic                                                         her_valid_i,
  output logic                                                         her_ready_o,
  input  pspin_descr_pkg::her_descr_t                                  her_i,

  output logic [pspin_cfg_pkg::NUM_MPQ-1:0]                            mpq_full_o,

  // Feedback to the NIC
  output logic                                                         nic_feedback_valid_o,
  input  logic                                                         nic_feedback_ready_i,
  output pspin_descr_pkg::feedback_descr_t                             nic_feedback_o,

  // Cluster task ports
  output logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_task_valid_o,
  input  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_task_ready_i,
  output pspin_descr_pkg::handler_task_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0]
                                                                       cluster_task_o,

  // Cluster feedback ports
  input  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_fb_valid_i,
  output logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_fb_ready_o,
  input  pspin_descr_pkg::feedback_descr_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0]
                                                                       cluster_fb_i
);

  // MPQ engine to scheduler
  logic                             task_valid;
  logic                             task_ready;
  pspin_descr_pkg::handler_task_t   task_descr;

  // Scheduler to MPQ engine
  logic                             fb_valid;
  logic                             fb_ready;
  pspin_descr_pkg::feedback_descr_t fb;

  mpq_engine i_mpq_engine (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .her_valid_i          (her_valid_i),
    .her_ready_o          (her_ready_o),
    .her_i                (her_i),
    .mpq_full_o           (mpq_full_o),
    .task_valid_o         (task_valid),
    .task_ready_i         (task_ready),
    .task_o               (task_descr),
    .fb_valid_i           (fb_valid),
    .fb_ready_o           (fb_ready),
    .fb_i                 (fb),
    .nic_feedback_valid_o (nic_feedback_valid_o),
    .nic_feedback_ready_i (nic_feedback_ready_i),
    .nic_feedback_o       (nic_feedback_o)
  );

  task_scheduler i_task_scheduler (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .task_valid_i         (task_valid),
    .task_ready_o         (task_ready),
    .task_i               (task_descr),
    .cluster_task_valid_o (cluster_task_valid_o),
    .cluster_task_ready_i (cluster_task_ready_i),
    .cluster_task_o       (cluster_task_o),
    .cluster_fb_valid_i   (cluster_fb_valid_i),
    .cluster_fb_ready_o   (cluster_fb_ready_o),
    .cluster_fb_i         (cluster_fb_i),
    .fb_valid_o           (fb_valid),
    .fb_ready_i           (fb_ready),
    .fb_o                 (fb)
  );

endmodule

//--- hdl/task_scheduler.sv
// Task scheduler for credit-limited dispatch of handler tasks to clusters and feedback collection
`timescale 1ns/10ps

module task_scheduler (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,

  input  logic                                                         task_valid_i,
  output logic                                                         task_ready_o,
  input  pspin_descr_pkg::handler_task_t                               task_i,

  output logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_task_valid_o,
  input  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_task_ready_i,
  output pspin_descr_pkg::handler_task_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0]
                                                                       cluster_task_o,

  input  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_fb_valid_i,
  output logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]                       cluster_fb_ready_o,
  input  pspin_descr_pkg::feedback_descr_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0]
                                                                       cluster_fb_i,

  output logic                                                         fb_valid_o,
  input  logic                                                         fb_ready_i,
  output pspin_descr_pkg::feedback_descr_t                             fb_o
);

  typedef logic [pspin_cfg_pkg::CLUSTER_ID_W-1:0] cl_idx_t;
  typedef logic [pspin_cfg_pkg::CREDIT_W-1:0]     credit_t;

  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]    avail;
  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]    task_fire;
  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]    fb_fire;
  credit_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0] credit_q;
  logic [pspin_cfg_pkg::NUM_CLUSTERS-1:0]    slot_valid_q;
  pspin_descr_pkg::handler_task_t [pspin_cfg_pkg::NUM_CLUSTERS-1:0] slot_task_q;

  cl_idx_t                          task_sel;
  logic                             task_accept;
  cl_idx_t                          fb_rr_q;
  logic                             fb_free;
  logic                             fb_valid_q;
  pspin_descr_pkg::feedback_descr_t fb_q;
  pspin_descr_pkg::feedback_descr_t fb_d;

  assign fb_free = !fb_valid_q || fb_ready_i;

  for (genvar c = 0; c < pspin_cfg_pkg::NUM_CLUSTERS; c++) begin : gen_cluster
    // A cluster can take a task if its slot is free and it still has credit
    assign avail[c]     = !slot_valid_q[c] && (credit_q[c] != '0);
    assign task_fire[c] = slot_valid_q[c] && cluster_task_ready_i[c];

    // Feedback is polled one cluster per cycle
    assign cluster_fb_ready_o[c] = fb_free && (fb_rr_q == cl_idx_t'(c));
    assign fb_fire[c]            = cluster_fb_valid_i[c] && cluster_fb_ready_o[c];

    // Credit leaves the range only if a cluster reports work it never got
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(task_fire[c] && !fb_fire[c] && credit_q[c] == '0) &&
      !(fb_fire[c] && !task_fire[c] &&
        credit_q[c] == credit_t'(pspin_cfg_pkg::NUM_HERS_PER_CLUSTER)))
      else $error("Cluster %0d credit out of range", c);
  end

  assign task_ready_o = |avail;
  assign task_accept  = task_valid_i && task_ready_o;

  // Lowest-indexed available cluster wins
  always_comb begin
    task_sel = '0;
    for (int c = pspin_cfg_pkg::NUM_CLUSTERS - 1; c >= 0; c--) begin
      if (avail[c]) begin
        task_sel = cl_idx_t'(c);
      end
    end
  end

  always_comb begin
    fb_d            = cluster_fb_i[fb_rr_q];
    fb_d.cluster_id = fb_rr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q     <= {pspin_cfg_pkg::NUM_CLUSTERS{
                        credit_t'(pspin_cfg_pkg::NUM_HERS_PER_CLUSTER)}};
      slot_valid_q <= '0;
      fb_rr_q      <= '0;
      fb_valid_q   <= 1'b0;
    end else begin
      for (int c = 0; c < pspin_cfg_pkg::NUM_CLUSTERS; c++) begin
        if (task_fire[c] && !fb_fire[c]) begin
          credit_q[c] <= credit_q[c] - 1'b1;
        end else if (fb_fire[c] && !task_fire[c]) begin
          credit_q[c] <= credit_q[c] + 1'b1;
        end
        if (task_accept && task_sel == cl_idx_t'(c)) begin
          slot_valid_q[c] <= 1'b1;
        end else if (cluster_task_ready_i[c]) begin
          slot_valid_q[c] <= 1'b0;
        end
      end
      if (fb_free) begin
        fb_rr_q <= cl_idx_t'((int'(fb_rr_q) + 1) % pspin_cfg_pkg::NUM_CLUSTERS);
      end
      if (|fb_fire) begin
        fb_valid_q <= 1'b1;
      end else if (fb_ready_i) begin
        fb_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (task_accept) begin
      slot_task_q[task_sel] <= task_i;
    end
    if (|fb_fire) begin
      fb_q <= fb_d;
    end
  end

  assign cluster_task_valid_o = slot_valid_q;
  assign cluster_task_o       = slot_task_q;
  assign fb_valid_o           = fb_valid_q;
  assign fb_o                 = fb_q;

endmodule
